// File: Makefile
# Verilator build and run of the log2 unit testbench

VERILATOR ?= verilator
TOP       ?= log2Unit_tb
OBJDIR    ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --assert
ERRLIMIT  ?= 1000

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard hw/*.svh)
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(OBJDIR)/V%: $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJDIR)

# pass only if the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN) +verilator+error+limit+$(ERRLIMIT))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Finished with no errors'

clean:
	rm -rf $(OBJDIR)

// File: all.f
+incdir+hw
hw/logTypesPkg.sv
hw/logCtrlPkg.sv
hw/leadOneLog2.sv
hw/mantNormalizer.sv
hw/fracSquarer.sv
hw/iterCounter.sv
hw/logCtrlFsm.sv
hw/log2Unit.sv
bench/log2Unit_asserts.sv
bench/log2Unit_tb.sv

// File: bench/log2Unit_asserts.sv
`timescale 1ns/1ps
`include "log_config.svh"
`default_nettype none

// handshake and latency properties, bound onto the log2Unit ports
module log2Unit_asserts (
	input logic                 clk,
	input logic                 arstN,
	input logic                 req,
	input logic                 ack,
	input logTypesPkg::intPartT intPart,
	input logTypesPkg::fracT    frac,
	input logic                 isZero
);

	// edge sampling req high in IDLE to edge sampling ack high
	localparam int lat = `LOG_FRAC_BITS + 3;

	int unsigned resetFails = 0;
	int unsigned latFails   = 0;
	int unsigned causeFails = 0;
	int unsigned holdFails  = 0;
	int unsigned dropFails  = 0;
	int unsigned failCount; // read by the testbench at the end

	assign failCount = resetFails + latFails + causeFails + holdFails + dropFails;

	// outputs cleared once reset lets go
	resetClear: assert property (@(posedge clk)
		$rose(arstN) |-> !ack && intPart == '0 && frac == '0 && !isZero)
	else begin
		resetFails++;
		$error("outputs not cleared by reset");
	end

	// fixed latency, zero operand too
	reqToAck: assert property (@(posedge clk) disable iff (!arstN)
		$rose(req) && !ack |-> ##lat $rose(ack))
	else begin
		latFails++;
		$error("ack did not rise LOG_FRAC_BITS+2 cycles after req");
	end

	// no ack without a request that started lat edges back
	ackCause: assert property (@(posedge clk) disable iff (!arstN)
		$rose(ack) |-> req && $past(req, lat))
	else begin
		causeFails++;
		$error("ack rose without a matching req");
	end

	// back-pressure, results frozen while req stays up
	holdStable: assert property (@(posedge clk) disable iff (!arstN)
		ack && req |=> ack && $stable(intPart) && $stable(frac) && $stable(isZero))
	else begin
		holdFails++;
		$error("ack or results moved while req was held");
	end

	ackDrop: assert property (@(posedge clk) disable iff (!arstN)
		ack && !req |=> !ack)
	else begin
		dropFails++;
		$error("ack still high one cycle after req fell");
	end

endmodule

`default_nettype wire

// File: bench/log2Unit_tb.sv
`timescale 1ns/1ps
`include "log_config.svh"
`default_nettype none

module log2Unit_tb;

	localparam int width       = `LOG_WIDTH;
	localparam int fracBits    = `LOG_FRAC_BITS;
	localparam int numRand     = 40;
	localparam int numOps      = numRand + width + 4; // plus 0, 1, all ones, 3 and powers of two
	localparam int maxHold     = 3;                   // extra cycles req stays up after ack
	localparam int resetCycles = 8;
	localparam longint timeoutNs = 10 * (numOps * (fracBits + 6 + maxHold) + resetCycles + 200);

	logic                 clk;
	logic                 arstN;
	logic                 req;
	logTypesPkg::operandT operand;
	logic                 ack;
	logTypesPkg::intPartT intPart;
	logTypesPkg::fracT    frac;
	logic                 isZero;

	logic [31:0] rngState;
	int unsigned errors;
	int unsigned checks;

	log2Unit u_log2Unit (
		.clk(clk),
		.arstN(arstN),
		.req(req),
		.operand(operand),
		.ack(ack),
		.intPart(intPart),
		.frac(frac),
		.isZero(isZero)
	);

	bind log2Unit log2Unit_asserts u_log2UnitAsserts (
		.clk(clk),
		.arstN(arstN),
		.req(req),
		.ack(ack),
		.intPart(intPart),
		.frac(frac),
		.isZero(isZero)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// index of the highest set bit, 0 for a zero operand
	function automatic logTypesPkg::intPartT refIntPart(input logTypesPkg::operandT a);
		logTypesPkg::intPartT r;
		r = '0;
		for (int i = 0; i < width; i++) begin
			if (a[i]) r = logTypesPkg::intPartT'(i);
		end
		return r;
	endfunction

	// squaring rule on the normalized mantissa, low bits truncated each step
	function automatic logTypesPkg::fracT refFrac(input logTypesPkg::operandT a,
			input logTypesPkg::intPartT ip);
		logic [2*width-1:0] m;  // 1.(width-1) value in the low width bits
		logic [2*width-1:0] sq; // 2.(2*width-2)
		logTypesPkg::fracT  f;
		m = {{width{1'b0}}, a} << (width - 1 - int'(ip));
		f = '0;
		for (int i = 0; i < fracBits; i++) begin
			sq = m * m;
			f[fracBits-1-i] = sq[2*width-1]; // square reached 2.0
			m = sq[2*width-1] ? (sq >> width) : (sq >> (width - 1)); // halve when >= 2
		end
		return f;
	endfunction

	// one full four-phase transfer, req held hold extra cycles after ack
	task automatic runOp(input logTypesPkg::operandT a, input int hold);
		logTypesPkg::intPartT expInt;
		logTypesPkg::fracT    expFrac;
		logic                 expZero;
		expInt  = refIntPart(a);
		expFrac = refFrac(a, expInt);
		expZero = (a == '0);
		@(posedge clk);
		#1;
		operand = a;
		req     = 1'b1;
		@(negedge clk);
		while (!ack) @(negedge clk);
		checks++;
		assert (intPart == expInt && frac == expFrac && isZero == expZero) else begin
			errors++;
			$display("CHECK FAILED at %0t: operand %h gave intPart %0d frac %h isZero %0b",
				$time, a, intPart, frac, isZero);
			$display("  expected intPart %0d frac %h isZero %0b", expInt, expFrac, expZero);
		end
		repeat (hold) @(posedge clk);
		@(posedge clk);
		#1;
		req = 1'b0;
		@(negedge clk);
		while (ack) @(negedge clk);
	endtask

	initial begin
		logTypesPkg::operandT a;
		int                   hold;
		int unsigned          assertFails;
		arstN    = 1'b0;
		req      = 1'b0;
		operand  = '0;
		errors   = 0;
		checks   = 0;
		rngState = 32'h5a15_12af;
		repeat (resetCycles) @(posedge clk);
		#1;
		arstN = 1'b1;

		runOp('0, 0); // zero flag case
		runOp(logTypesPkg::operandT'(1), 1);
		for (int i = 0; i < width; i++) begin
			runOp(logTypesPkg::operandT'(1) << i, i % (maxHold + 1)); // exact powers
		end
		runOp('1, 2);
		runOp(logTypesPkg::operandT'(3), 0);

		for (int i = 0; i < numRand; i++) begin
			rngState = xorshift(rngState);
			a        = logTypesPkg::operandT'(rngState);
			rngState = xorshift(rngState);
			a        = a >> (rngState % width); // spread the leading one
			rngState = xorshift(rngState);
			hold     = int'(rngState % (maxHold + 1));
			runOp(a, hold);
		end

		repeat (3) @(posedge clk); // let the last properties finish
		assertFails = u_log2Unit.u_log2UnitAsserts.failCount;
		$display("checks %0d, value errors %0d, assertion failures %0d",
			checks, errors, assertFails);
		if (errors == 0 && assertFails == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	initial begin
		#(timeoutNs);
		$display("watchdog expired after %0d ns, the DUT stopped answering", timeoutNs);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/fracSquarer.sv
`timescale 1ns/1ps
`default_nettype none

// fraction bits of log2 by repeated squaring
// m in [1,2), m*m >= 2 means the next bit is 1 and m*m/2 carries on
module fracSquarer (
	input  logic               clk,
	input  logic               arstN,
	input  logic               start,  // load mantIn, clear the bits
	input  logic               step,   // one squaring step
	input  logic               latch,  // copy the finished bits to frac
	input  logTypesPkg::mantT  mantIn,
	output logTypesPkg::fracT  frac
);

	localparam int mw = $bits(logTypesPkg::mantT);

	typedef logic [2*mw-1:0] sqT; // 2.(2*mw-2) fixed point

	logTypesPkg::mantT curMant;  // running mantissa
	logTypesPkg::mantT nextMant;
	logTypesPkg::fracT fracReg;  // bits so far, newest in the lsb
	sqT                sq;
	logic              geTwo;    // square reached 2

	assign sq    = sqT'(curMant) * sqT'(curMant);
	assign geTwo = sq[2*mw-1];

	// back to 1.(mw-1), halving when the square is 2 or more
	// truncation drops the low half
	assign nextMant = geTwo ? sq[2*mw-1 -: mw] : sq[2*mw-2 -: mw];

	always_ff @(posedge clk) begin
		if (start) begin
			curMant <= mantIn;
			fracReg <= '0;
		end else if (step) begin
			curMant <= nextMant;
			fracReg <= logTypesPkg::fracT'({fracReg, geTwo}); // shift in at the lsb
		end
	end

	// result register, stays put while the next operand is worked on
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			frac <= '0;
		end else if (latch) begin
			frac <= fracReg;
		end
	end

endmodule

`default_nettype wire

// File: hw/iterCounter.sv
`timescale 1ns/1ps
`include "log_config.svh"
`default_nettype none

// squaring steps still to go
module iterCounter (
	input  logic clk,
	input  logic arstN,
	input  logic load, // start a new operation
	input  logic dec,  // one step taken
	output logic done  // no steps left
);

	logCtrlPkg::iterCntT cnt;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			cnt <= '0;
		end else if (load) begin
			cnt <= logCtrlPkg::iterCntT'(`LOG_FRAC_BITS);
		end else if (dec && !done) begin
			cnt <= cnt - 1'b1; // holds at zero
		end
	end

	// high from the cycle after the last step
	assign done = (cnt == '0);

endmodule

`default_nettype wire

// File: hw/leadOneLog2.sv
`timescale 1ns/1ps
`include "log_config.svh"
`default_nettype none

// floor(log2 a) of an unsigned word, combinational
// a == 0 gives z == 0
module intLog2 (
	input  logTypesPkg::operandT a, // operand
	output logTypesPkg::intPartT z  // index of the leading one
);

	localparam int opWidth = $bits(logTypesPkg::operandT);

	logic [opWidth-1:0] leadOne; // one-hot, only the msb set bit of a

	leadZeroDet #(
		.width(opWidth),
		.speed(`LOG_SPEED)
	) u_leadZeroDet (
		.a(a),
		.z(leadOne)
	);

	// one-hot to binary
	onehotEncode #(
		.width(opWidth)
	) u_onehotEncode (
		.a(leadOne),
		.z(z)
	);

endmodule

// keeps only the most significant one of a
// e.g. 0010_1100 -> 0010_0000
module leadZeroDet #(
	parameter int width = 8, // word width
	parameter int speed = 0  // prefix network choice
) (
	input  logic [width-1:0] a,
	output logic [width-1:0] z
);

	logic [width-1:0] piRev; // ~a, msb first
	logic [width-1:0] poRev; // bit k set while a has no one in its top k+1 bits

	// flip so the scan runs from the msb down
	for (genvar i = 0; i < width; i++) begin : flip
		assign piRev[i] = ~a[width-1-i];
	end

	prefixAnd #(
		.width(width),
		.speed(speed)
	) u_prefixAnd (
		.pi(piRev),
		.po(poRev)
	);

	assign z[width-1] = a[width-1]; // nothing above the msb
	for (genvar i = 0; i < width-1; i++) begin : pick
		assign z[i] = a[i] & poRev[width-2-i]; // set bit with only zeros above
	end

endmodule

// prefix AND, po[j] = &pi[j:0]
module prefixAnd #(
	parameter int width = 8, // word width
	parameter int speed = 0  // 0 serial, 1 Brent-Kung, 2 Sklansky
) (
	input  logic [width-1:0] pi, // propagate in
	output logic [width-1:0] po  // propagate out
);

	localparam int m = $clog2(width); // tree depth

	if (speed == 2) begin : sklansky
		logic [m:0][width-1:0] lvl;

		assign lvl[0] = pi;
		for (genvar l = 1; l <= m; l++) begin : stage
			for (genvar j = 0; j < width; j++) begin : node
				// upper half of each 2^l block takes the lower half's last node
				if (((j >> (l-1)) & 1) == 1) begin : merge
					assign lvl[l][j] = lvl[l-1][j] & lvl[l-1][((j >> (l-1)) << (l-1)) - 1];
				end else begin : pass
					assign lvl[l][j] = lvl[l-1][j];
				end
			end
		end
		assign po = lvl[m];
	end else if (speed == 1) begin : brentKung
		logic [2*m-1:0][width-1:0] lvl;

		assign lvl[0] = pi;
		// up-sweep, block ends gather their 2^l block
		for (genvar l = 1; l <= m; l++) begin : up
			for (genvar j = 0; j < width; j++) begin : node
				if ((j + 1) % (1 << l) == 0) begin : merge
					assign lvl[l][j] = lvl[l-1][j] & lvl[l-1][j - (1 << (l-1))];
				end else begin : pass
					assign lvl[l][j] = lvl[l-1][j];
				end
			end
		end
		// down-sweep, mid-block nodes pick up the finished prefix below them
		for (genvar u = 1; u <= m-1; u++) begin : down
			for (genvar j = 0; j < width; j++) begin : node
				if ((j + 1) % (1 << (m-u)) == (1 << (m-u-1)) && j >= (1 << (m-u))) begin : merge
					assign lvl[m+u][j] = lvl[m+u-1][j] & lvl[m+u-1][j - (1 << (m-u-1))];
				end else begin : pass
					assign lvl[m+u][j] = lvl[m+u-1][j];
				end
			end
		end
		assign po = lvl[2*m-1];
	end else begin : serial
		logic [width-1:0] run; // ripple chain

		assign run[0] = pi[0];
		for (genvar j = 1; j < width; j++) begin : node
			assign run[j] = run[j-1] & pi[j];
		end
		assign po = run;
	end

endmodule

// one-hot to binary, z[b] is the OR of all a[i] with bit b set in i
module onehotEncode #(
	parameter int width = 8 // input width
) (
	input  logic [width-1:0]         a,
	output logic [$clog2(width)-1:0] z
);

	always_comb begin
		z = '0;
		for (int b = 0; b < $clog2(width); b++) begin
			for (int i = 0; i < width; i++) begin
				if (((i >> b) & 1) != 0) begin
					z[b] = z[b] | a[i];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/log2Unit.sv
`timescale 1ns/1ps
`default_nettype none

// log2 of an unsigned word, integer part plus truncated fraction
// one operation at a time behind a four-phase req/ack
module log2Unit (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 req,
	input  logTypesPkg::operandT operand, // stable while req is high
	output logic                 ack,
	output logTypesPkg::intPartT intPart,
	output logTypesPkg::fracT    frac,
	output logic                 isZero
);

	logTypesPkg::intPartT lzPos; // leading-one index of the live operand
	logTypesPkg::mantT    mant;
	logic                 normLoad;
	logic                 sqStart;
	logic                 sqStep;
	logic                 cntLoad;
	logic                 resLatch;
	logic                 iterDone;

	intLog2 u_intLog2 (
		.a(operand),
		.z(lzPos)
	);

	mantNormalizer u_mantNormalizer (
		.clk(clk),
		.arstN(arstN),
		.load(normLoad),
		.operand(operand),
		.lzPos(lzPos),
		.mant(mant),
		.intPart(intPart),
		.isZero(isZero)
	);

	fracSquarer u_fracSquarer (
		.clk(clk),
		.arstN(arstN),
		.start(sqStart),
		.step(sqStep),
		.latch(resLatch),
		.mantIn(mant),
		.frac(frac)
	);

	iterCounter u_iterCounter (
		.clk(clk),
		.arstN(arstN),
		.load(cntLoad),
		.dec(sqStep),
		.done(iterDone)
	);

	logCtrlFsm u_logCtrlFsm (
		.clk(clk),
		.arstN(arstN),
		.req(req),
		.iterDone(iterDone),
		.ack(ack),
		.normLoad(normLoad),
		.sqStart(sqStart),
		.sqStep(sqStep),
		.cntLoad(cntLoad),
		.resLatch(resLatch)
	);

endmodule

`default_nettype wire

// File: hw/logCtrlFsm.sv
`timescale 1ns/1ps
`default_nettype none

// four-phase req/ack and the step sequence
// each strobe fires in the cycle whose closing edge does its job,
// so req sampled in IDLE to ack high is LOG_FRAC_BITS+2 cycles
module logCtrlFsm (
	input  logic clk,
	input  logic arstN,
	input  logic req,
	input  logic iterDone, // all squaring steps taken
	output logic ack,
	output logic normLoad, // operand into the normalizer
	output logic sqStart,  // normalized mantissa into the squarer
	output logic sqStep,   // one squaring step
	output logic cntLoad,  // restart the step counter
	output logic resLatch  // fraction into its output register
);

	logCtrlPkg::stateT state;
	logCtrlPkg::stateT nextState;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= logCtrlPkg::IDLE;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		unique case (state)
			logCtrlPkg::IDLE: if (req) nextState = logCtrlPkg::NORM;
			logCtrlPkg::NORM: nextState = logCtrlPkg::ITER; // always one cycle
			logCtrlPkg::ITER: if (iterDone) nextState = logCtrlPkg::DONE;
			logCtrlPkg::DONE: if (!req) nextState = logCtrlPkg::IDLE; // wait for req to drop
			default: nextState = logCtrlPkg::IDLE;
		endcase
	end

	// normalizer and counter load on the edge into NORM
	assign normLoad = (state == logCtrlPkg::IDLE) && req;
	assign cntLoad  = (state == logCtrlPkg::IDLE) && req;

	assign sqStart  = (state == logCtrlPkg::NORM); // mant valid here, squarer takes it
	assign sqStep   = (state == logCtrlPkg::ITER) && !iterDone;
	assign resLatch = (state == logCtrlPkg::ITER) && iterDone; // edge into DONE

	assign ack = (state == logCtrlPkg::DONE); // low again the edge after req drops

endmodule

`default_nettype wire

// File: hw/logCtrlPkg.sv
`include "log_config.svh"
`default_nettype none

// controller side types
package logCtrlPkg;

	// sequencing states
	typedef enum logic [1:0] {
		IDLE, // waiting for req
		NORM, // mantissa just normalized
		ITER, // squaring steps
		DONE  // results out, ack high
	} stateT;

	// squaring steps left, must hold LOG_FRAC_BITS itself
	typedef logic [$clog2(`LOG_FRAC_BITS+1)-1:0] iterCntT;

endpackage

`default_nettype wire

// File: hw/logTypesPkg.sv
`include "log_config.svh"
`default_nettype none

// datapath types of the log2 unit
package logTypesPkg;

	// unsigned input word
	typedef logic [`LOG_WIDTH-1:0] operandT;

	// floor(log2) of the operand, also the leading-one index
	typedef logic [$clog2(`LOG_WIDTH)-1:0] intPartT;

	// normalized mantissa, fixed point 1.(LOG_WIDTH-1)
	// msb is the integer bit, value kept in [1,2)
	typedef logic [`LOG_WIDTH-1:0] mantT;

	// fraction of the log, first computed bit in the msb
	typedef logic [`LOG_FRAC_BITS-1:0] fracT;

endpackage

`default_nettype wire

// File: hw/log_config.svh
`ifndef LOG_CONFIG_SVH
`define LOG_CONFIG_SVH

`default_nettype none

// operand width in bits
// power of two, 4 up to 32
`define LOG_WIDTH 16

// fraction bits of the result, one squaring step each
`define LOG_FRAC_BITS 8

// prefix network of the leading-one detector
// 0 serial, smallest and slowest
// 1 Brent-Kung
// 2 Sklansky, shallowest
`define LOG_SPEED 2

`default_nettype wire

`endif

// File: hw/mantNormalizer.sv
`timescale 1ns/1ps
`default_nettype none

// moves the leading one to the msb, so the mantissa lands in [1,2)
// also keeps intPart and the zero flag for the result
module mantNormalizer (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 load,    // take a new operand
	input  logTypesPkg::operandT operand,
	input  logTypesPkg::intPartT lzPos,   // leading-one index
	output logTypesPkg::mantT    mant,    // normalized, 1.(W-1) fixed point
	output logTypesPkg::intPartT intPart, // held copy of lzPos
	output logic                 isZero
);

	localparam int opWidth = $bits(logTypesPkg::operandT);

	logTypesPkg::intPartT shAmt; // left shift to normalize

	assign shAmt = logTypesPkg::intPartT'(opWidth - 1) - lzPos;

	always_ff @(posedge clk) begin
		if (load) begin
			mant <= logTypesPkg::mantT'(operand << shAmt); // zero operand stays zero
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			intPart <= '0;
			isZero  <= 1'b0;
		end else if (load) begin
			intPart <= lzPos;
			isZero  <= (operand == '0);
		end
	end

endmodule

`default_nettype wire
